// File: mq_pkg.sv
/*
  Queue-side definitions for the shared-buffer multi-queue.
  Holds the number of logical queues and the types for queue ids,
  occupancy counts and data items.
*/
`default_nettype none

package mq_pkg;

  localparam int num_que = 8;
  localparam int que_w   = $clog2(num_que);

  // a count must reach 64, the whole buffer in one queue.
  localparam int cnt_w  = 7;
  localparam int item_w = 16;

  typedef logic [que_w-1:0]  que_t;
  typedef logic [cnt_w-1:0]  cnt_t;
  typedef logic [item_w-1:0] item_t;

endpackage

`default_nettype wire

// File: mem_pkg.sv
/*
  Buffer memory definitions: entry count, pointer and stack level types.
*/
`default_nettype none

package mem_pkg;

  localparam int num_buf = 64;
  localparam int ptr_w   = $clog2(num_buf);

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [ptr_w:0]   lvl_t;  // one bit wider so a full stack fits.

endpackage

`default_nettype wire

// File: mem_if.sv
/*
  Simple dual-port memory interface.
  One write port and one read port, payload type set per instance.
  Read data returns one cycle after the read strobe.
*/
`timescale 1ns/1ns
`default_nettype none

interface mem_if #(
  parameter type payload_t = logic
);
  import mem_pkg::*;

  logic     we;
  ptr_t     waddr;
  payload_t wdata;
  logic     re;
  ptr_t     raddr;
  payload_t rdata;

  modport ctrl (output we, waddr, wdata, re, raddr, input rdata);
  modport mem (input we, waddr, wdata, re, raddr, output rdata);

endinterface

`default_nettype wire

// File: dp_ram.sv
/*
  One-write, one-read synchronous RAM with a registered read.
  A write and a read to the same address in one cycle return the new word.
*/
`timescale 1ns/1ns
`default_nettype none

module dp_ram #(
  parameter type payload_t = logic
) (
  input logic clk,
  mem_if.mem  mem
);
  import mem_pkg::*;

  payload_t ram [num_buf];

  always_ff @(posedge clk) begin
    if (mem.we) begin
      ram[mem.waddr] <= mem.wdata;
    end
    if (mem.re) begin
      if (mem.we && (mem.waddr == mem.raddr)) begin
        mem.rdata <= mem.wdata;  // bypass the array on a collision.
      end else begin
        mem.rdata <= ram[mem.raddr];
      end
    end
  end

endmodule

`default_nettype wire

// File: free_list.sv
/*
  Free pointer list.
  A stack that starts out holding every buffer pointer. alloc takes the
  top entry and rel returns one. When both fire together the returned
  pointer goes straight back out and the stack is left alone.
*/
`timescale 1ns/1ns
`default_nettype none

module free_list (
  input  logic          clk,
  input  logic          rst,
  input  logic          alloc,
  output mem_pkg::ptr_t alloc_ptr,
  output logic          avail,
  input  logic          rel,
  input  mem_pkg::ptr_t rel_ptr
);
  import mem_pkg::*;

  ptr_t stk [num_buf];
  lvl_t lvl;
  ptr_t top_idx;

  assign top_idx = ptr_t'(lvl - 1'b1);
  assign avail = (lvl != '0);

  // a pointer coming back this cycle is handed out ahead of the stack.
  assign alloc_ptr = rel ? rel_ptr : stk[top_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_buf; i++) begin
        stk[i] <= ptr_t'(i);
      end
      lvl <= lvl_t'(num_buf);
    end else begin
      if (alloc && !rel) begin
        lvl <= lvl - 1'b1;
      end else if (rel && !alloc) begin
        stk[ptr_t'(lvl)] <= rel_ptr;
        lvl <= lvl + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: occ_monitor.sv
/*
  Occupancy monitor.
  Counts the entries of every queue, refuses a pop on an empty queue
  with a one-cycle error pulse, and answers host reads of a count.
*/
`timescale 1ns/1ns
`default_nettype none

module occ_monitor (
  input  logic         clk,
  input  logic         rst,
  input  logic         push_acc,
  input  mq_pkg::que_t pu_que,
  input  logic         pop,
  input  mq_pkg::que_t po_que,
  output logic         pop_acc,
  output logic         po_err,
  input  logic         cp_read,
  input  mq_pkg::que_t cp_adr,
  output logic         cp_vld,
  output mq_pkg::cnt_t cp_dout
);
  import mq_pkg::*;

  cnt_t cnt [num_que];
  que_t cp_adr_q;

  assign pop_acc = pop && (cnt[po_que] != '0);
  assign cp_dout = cnt[cp_adr_q];  // counts already hold the updates of the request cycle.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int q = 0; q < num_que; q++) begin
        cnt[q] <= '0;
      end
      po_err <= 1'b0;
      cp_vld <= 1'b0;
    end else begin
      for (int q = 0; q < num_que; q++) begin
        cnt[q] <= cnt[q] + cnt_t'(push_acc && (pu_que == que_t'(q)))
                         - cnt_t'(pop_acc && (po_que == que_t'(q)));
      end
      po_err <= pop && !pop_acc;
      cp_vld <= cp_read;
    end
  end

  always_ff @(posedge clk) begin
    cp_adr_q <= cp_adr;
  end

endmodule

`default_nettype wire

// File: queue_ctrl.sv
/*
  Queue controller.
  Keeps a head and tail pointer per queue, with the entries of each
  queue chained through the link memory. A push writes the item and
  links it behind the old tail. A pop reads the head item and its link,
  then loads the new head and frees the old one a cycle later.
*/
`timescale 1ns/1ns
`default_nettype none

module queue_ctrl (
  input  logic          clk,
  input  logic          rst,
  input  logic          push,
  input  mq_pkg::que_t  pu_que,
  input  mq_pkg::item_t pu_din,
  output logic          push_acc,
  input  logic          pop,
  input  mq_pkg::que_t  po_que,
  input  logic          pop_acc,
  output logic          pop_rdy,
  output logic          po_vld,
  output mq_pkg::item_t po_dout,
  output logic          alloc,
  input  mem_pkg::ptr_t alloc_ptr,
  input  logic          avail,
  output logic          rel,
  output mem_pkg::ptr_t rel_ptr,
  mem_if.ctrl           link,
  mem_if.ctrl           data
);
  import mq_pkg::*;
  import mem_pkg::*;

  ptr_t               head [num_que];
  ptr_t               tail [num_que];
  logic [num_que-1:0] emp;
  logic               pu_emp;
  logic               pop_fire;
  logic               pop_last;
  logic               pop_busy;
  logic               pop_adv;
  que_t               pop_q;
  ptr_t               pop_ptr;

  assign push_acc = push && avail;
  assign pu_emp   = emp[pu_que];
  assign pop_fire = pop && pop_rdy && pop_acc;

  // a one-entry queue drains, unless a push on it refills it now.
  assign pop_last = (head[po_que] == tail[po_que]) && !(push_acc && (pu_que == po_que));

  assign pop_rdy = !pop_busy;  // low while the next head is in flight.
  assign po_vld  = pop_busy;
  assign po_dout = data.rdata;
  assign alloc   = push_acc;
  assign rel     = pop_busy;
  assign rel_ptr = pop_ptr;

  assign data.we    = push_acc;
  assign data.waddr = alloc_ptr;
  assign data.wdata = pu_din;
  assign data.re    = pop_fire;
  assign data.raddr = head[po_que];

  // an empty queue has no tail to link from.
  assign link.we    = push_acc && !pu_emp;
  assign link.waddr = tail[pu_que];
  assign link.wdata = alloc_ptr;
  assign link.re    = pop_fire;
  assign link.raddr = head[po_que];

  always_ff @(posedge clk) begin
    if (rst) begin
      emp      <= '1;
      pop_busy <= 1'b0;
    end else begin
      pop_busy <= pop_fire;
      if (push_acc) begin
        emp[pu_que] <= 1'b0;
      end
      if (pop_fire && pop_last) begin
        emp[po_que] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    pop_q   <= po_que;
    pop_ptr <= head[po_que];
    pop_adv <= pop_fire && !pop_last;
    if (push_acc) begin
      tail[pu_que] <= alloc_ptr;
      if (pu_emp) begin
        head[pu_que] <= alloc_ptr;
      end
    end
    // the link word of the old head names the next entry.
    if (pop_adv) begin
      head[pop_q] <= link.rdata;
    end
  end

endmodule

`default_nettype wire

// File: mq_buffer_top.sv
/*
  Shared-buffer multi-queue.
  Eight FIFO queues of 16-bit items kept as linked lists in one
  64-entry buffer, with per-queue occupancy counts readable by the host.
*/
`timescale 1ns/1ns
`default_nettype none

module mq_buffer_top (
  input  logic          clk,
  input  logic          rst,
  input  logic          push,
  input  mq_pkg::que_t  pu_que,
  input  mq_pkg::item_t pu_din,
  output logic          full,
  input  logic          pop,
  input  mq_pkg::que_t  po_que,
  output logic          pop_rdy,
  output logic          po_vld,
  output mq_pkg::item_t po_dout,
  output logic          po_err,
  input  logic          cp_read,
  input  mq_pkg::que_t  cp_adr,
  output logic          cp_vld,
  output mq_pkg::cnt_t  cp_dout
);
  import mq_pkg::*;
  import mem_pkg::*;

  logic push_acc;
  logic pop_acc;
  logic alloc;
  ptr_t alloc_ptr;
  logic avail;
  logic rel;
  ptr_t rel_ptr;

  mem_if #(.payload_t(ptr_t))  link_if ();
  mem_if #(.payload_t(item_t)) data_if ();

  assign full = !avail;

  free_list u_free_list (
    .clk, .rst, .alloc, .alloc_ptr, .avail, .rel, .rel_ptr
  );

  queue_ctrl u_queue_ctrl (
    .clk, .rst, .push, .pu_que, .pu_din, .push_acc,
    .pop, .po_que, .pop_acc, .pop_rdy, .po_vld, .po_dout,
    .alloc, .alloc_ptr, .avail, .rel, .rel_ptr,
    .link (link_if.ctrl),
    .data (data_if.ctrl)
  );

  // only a pop offered while pop_rdy is high is judged for emptiness.
  occ_monitor u_occ_monitor (
    .clk, .rst, .push_acc, .pu_que,
    .pop (pop && pop_rdy),
    .po_que, .pop_acc, .po_err, .cp_read, .cp_adr, .cp_vld, .cp_dout
  );

  dp_ram #(.payload_t(ptr_t)) link_ram (
    .clk,
    .mem (link_if.mem)
  );

  dp_ram #(.payload_t(item_t)) data_ram (
    .clk,
    .mem (data_if.mem)
  );

endmodule

`default_nettype wire

// File: tb_mq_buffer.sv
/*
  Testbench for the shared-buffer multi-queue.
  A reference model keeps every queue and the free count. The compare
  process checks the DUT outputs against it on each falling edge.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_mq_buffer;
  import mq_pkg::*;
  import mem_pkg::*;

  localparam int wait_limit = 50;

  logic  clk;
  logic  rst;
  logic  push;
  que_t  pu_que;
  item_t pu_din;
  logic  full;
  logic  pop;
  que_t  po_que;
  logic  pop_rdy;
  logic  po_vld;
  item_t po_dout;
  logic  po_err;
  logic  cp_read;
  que_t  cp_adr;
  logic  cp_vld;
  cnt_t  cp_dout;

  item_t m_mem [num_que][num_buf];
  ptr_t  m_rd [num_que];
  ptr_t  m_wr [num_que];
  int    m_cnt [num_que];
  int    m_free;
  logic  m_rel;  // a popped pointer returns to the free list one cycle later.
  logic  m_rdy;
  logic  exp_vld;
  logic  exp_err;
  item_t exp_dout;
  logic  exp_cp_vld;
  que_t  exp_cp_adr;
  int    exp_cnt;

  int     n_checks = 0;
  int     n_errors = 0;
  logic   timed_out = 1'b0;
  integer seed = 32'he11d;

  mq_buffer_top uut (
    .clk, .rst, .push, .pu_que, .pu_din, .full, .pop, .po_que, .pop_rdy,
    .po_vld, .po_dout, .po_err, .cp_read, .cp_adr, .cp_vld, .cp_dout
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check(input string what, input int got, input int want);
    n_checks++;
    if (got != want) begin
      n_errors++;
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, want);
    end
  endtask

  function automatic void model_reset();
    for (int q = 0; q < num_que; q++) begin
      m_cnt[q] = 0;
      m_rd[q] = '0;
      m_wr[q] = '0;
    end
    m_free = num_buf;
    m_rel = 1'b0;
    m_rdy = 1'b1;
    exp_vld = 1'b0;
    exp_err = 1'b0;
    exp_dout = '0;
    exp_cp_vld = 1'b0;
    exp_cp_adr = '0;
    exp_cnt = 0;
  endfunction

  // one cycle of the accept rules, with the inputs seen in that cycle.
  function automatic void model_cycle(input logic pu, input que_t pq, input item_t d,
                                      input logic po, input que_t oq,
                                      input logic rd, input que_t ra);
    logic pu_ok;
    logic po_ok;
    pu_ok = pu && (m_free != 0);
    po_ok = po && m_rdy && (m_cnt[oq] != 0);
    exp_err = po && m_rdy && (m_cnt[oq] == 0);
    exp_vld = po_ok;
    if (po_ok) begin
      exp_dout = m_mem[oq][m_rd[oq]];  // the old head, even if a push lands on it now.
      m_rd[oq] = m_rd[oq] + 1'b1;
      m_cnt[oq]--;
    end
    if (pu_ok) begin
      m_mem[pq][m_wr[pq]] = d;
      m_wr[pq] = m_wr[pq] + 1'b1;
      m_cnt[pq]++;
    end
    m_free = m_free - int'(pu_ok) + int'(m_rel);
    m_rel = po_ok;
    m_rdy = !po_ok;
    exp_cp_vld = rd;
    exp_cp_adr = ra;
    exp_cnt = m_cnt[ra];
  endfunction

  always @(negedge clk) begin
    if (rst !== 1'b0) begin
      model_reset();
    end else begin
      check("po_vld", int'(po_vld), int'(exp_vld));
      check("po_err", int'(po_err), int'(exp_err));
      check("cp_vld", int'(cp_vld), int'(exp_cp_vld));
      if (exp_vld) begin
        check("po_dout", int'(po_dout), int'(exp_dout));
      end
      if (exp_cp_vld) begin
        check($sformatf("cp_dout of queue %0d", exp_cp_adr), int'(cp_dout), exp_cnt);
      end
      check("full", int'(full), int'(m_free == 0));
      check("pop_rdy", int'(pop_rdy), int'(m_rdy));
      model_cycle(push, pu_que, pu_din, pop, po_que, cp_read, cp_adr);
    end
  end

  task automatic step(input logic pu, input que_t pq, input item_t d, input logic po,
                      input que_t oq, input logic rd, input que_t ra);
    @(posedge clk);
    push    <= pu;
    pu_que  <= pq;
    pu_din  <= d;
    pop     <= po;
    po_que  <= oq;
    cp_read <= rd;
    cp_adr  <= ra;
  endtask

  task automatic idle();
    step(1'b0, '0, '0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic push_one(input que_t q, input item_t d);
    step(1'b1, q, d, 1'b0, '0, 1'b0, '0);
  endtask

  // waits for pop_rdy, or for full when want_full is set.
  task automatic wait_ready(input logic want_full);
    int n;
    n = 0;
    if (!timed_out) begin
      @(negedge clk);
      while ((want_full ? !full : !pop_rdy) && n < wait_limit) begin
        idle();
        @(negedge clk);
        n++;
      end
      if (want_full ? !full : !pop_rdy) begin
        $display("timeout: %s still low after %0d cycles at %0t",
                 want_full ? "full" : "pop_rdy", wait_limit, $time);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic pop_one(input que_t q);
    wait_ready(1'b0);
    step(1'b0, '0, '0, 1'b1, q, 1'b0, '0);
    idle();
  endtask

  task automatic read_counts();
    for (int q = 0; q < num_que; q++) begin
      step(1'b0, '0, '0, 1'b0, '0, 1'b1, que_t'(q));
    end
    idle();
  endtask

  task automatic drain_all();
    idle();  // lets the model see the last request first.
    for (int q = 0; q < num_que; q++) begin
      while (m_cnt[q] != 0 && !timed_out) begin
        pop_one(que_t'(q));
      end
    end
  endtask

  task automatic report(input string name, input int e0);
    $display("test %-14s done, %0d errors", name, n_errors - e0);
  endtask

  initial begin
    int e0;
    logic [31:0] r;
    rst <= 1'b1;
    push <= 1'b0;
    pu_que <= '0;
    pu_din <= '0;
    pop <= 1'b0;
    po_que <= '0;
    cp_read <= 1'b0;
    cp_adr <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    e0 = n_errors;
    for (int i = 0; i < 24; i++) begin
      push_one(que_t'((i * 3) % 8), item_t'(16'h1000 + i));
    end
    drain_all();
    report("fifo order", e0);

    e0 = n_errors;
    pop_one(3'd2);  // every queue is empty at this point.
    read_counts();
    report("empty pop", e0);

    e0 = n_errors;
    for (int i = 0; i < num_buf; i++) begin
      push_one(que_t'(i % 8), item_t'($random(seed)));
    end
    wait_ready(1'b1);
    push_one(3'd0, 16'hdead);
    read_counts();
    report("full buffer", e0);

    e0 = n_errors;
    for (int i = 0; i < 16; i++) begin
      pop_one(que_t'(i % 8));
    end
    for (int i = 0; i < 16; i++) begin
      push_one(que_t'((i * 5) % 8), item_t'(16'h4000 + i));
    end
    read_counts();
    drain_all();
    report("pointer reuse", e0);

    e0 = n_errors;
    push_one(3'd5, 16'h5a5a);
    wait_ready(1'b0);
    step(1'b1, 3'd5, 16'h5a5b, 1'b1, 3'd5, 1'b0, '0);
    idle();
    for (int i = 0; i < 300; i++) begin
      r = $random(seed);
      step(r[0], que_t'(r[5:4]), r[31:16], r[1], que_t'(r[7:6]), r[8], r[11:9]);
    end
    read_counts();
    drain_all();
    report("count reads", e0);

    e0 = n_errors;
    push_one(3'd6, 16'h6001);
    push_one(3'd6, 16'h6002);
    wait_ready(1'b0);
    step(1'b0, '0, '0, 1'b1, 3'd6, 1'b0, '0);
    step(1'b0, '0, '0, 1'b1, 3'd6, 1'b0, '0);  // lands while pop_rdy is low.
    idle();
    read_counts();
    drain_all();
    report("pop_rdy", e0);

    idle();
    idle();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
mq_pkg.sv
mem_pkg.sv
mem_if.sv
dp_ram.sv
free_list.sv
occ_monitor.sv
queue_ctrl.sv
mq_buffer_top.sv
tb_mq_buffer.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mq_buffer
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= TEST RESULT: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
